//--- mem_sub.f
+incdir+common
common/mem_sub_pkg.sv
ram/dual_port_ram.sv
logic/axil_data_port.sv
logic/instr_fetch.sv
logic/fetch_queue.sv
logic/instr_decode.sv
logic/mem_sub_top.sv
verif/tb_mem_sub.sv

//--- Makefile
# Verilator simulation of the memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_sub
FILELIST  ?= mem_sub.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_mem_sub.sv
// testbench for the memory subsystem
// axi4-lite host with a byte model of the ram, random programs run
// through fetch and decode under back-pressure and redirects

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module tb_mem_sub;

    localparam int            AW         = `MEM_SUB_ADDR_W;
    localparam logic [AW-1:0] RESET_PC   = `MEM_SUB_RESET_PC;
    localparam int            N_AXI_WR   = 64;     // random strobe writes
    localparam int            N_AXI_RD   = 16;     // one read per pool word
    localparam int            N_PROG     = 96;     // program words at the reset pc
    localparam int            N_SEQ      = 32;
    localparam int            N_BP       = 32;
    localparam int            N_RED      = 8;
    localparam int            N_RED_TAIL = 8;
    localparam int            N_LATE     = 16;     // words written ahead of fetch
    localparam int            N_LATE_DEC = 12;
    localparam int            LIMIT      = 10 * (N_AXI_WR + N_AXI_RD + N_PROG + N_SEQ + N_BP
                                           + N_RED + N_RED_TAIL + N_LATE + N_LATE_DEC);

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic                       aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
    logic                       b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
    logic                       r_valid_o, r_ready_i;
    mem_sub_pkg::axil_aw_t      aw_i;
    mem_sub_pkg::axil_w_t       w_i;
    mem_sub_pkg::axil_b_t       b_o;
    mem_sub_pkg::axil_ar_t      ar_i;
    mem_sub_pkg::axil_r_t       r_o;
    logic                       fetch_en_i, redirect_valid_i, dec_valid_o, dec_ready_i;
    logic [AW-1:0]              redirect_pc_i;
    mem_sub_pkg::decoded_t      dec_o;

    integer                     seed       = 11477;
    integer                     ready_seed = 11477 ^ 32'h5a5a;  // own stream for dec_ready_i
    logic [7:0]                 model_mem [0:65535];            // byte image of the ram
    logic [AW-1:0]              pool [16];                      // axi test addresses
    int                         idx;
    logic [31:0]                r, s;
    int                         errors = 0, checks = 0, test_errs = 0, cycles = 0;
    logic                       rand_ready = 1'b0;
    logic                       mon_en = 1'b0;
    logic [AW-1:0]              exp_pc = RESET_PC;              // pc of the next transfer
    int                         dec_count = 0;
    logic                       stalled = 1'b0;
    mem_sub_pkg::decoded_t      held;

    always #2 clk = ~clk;                       // 4 ns period

    mem_sub_top i_dut (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;                                     // inputs change 1 ns after the edge
    endtask

    task automatic check_low(input logic v, input string name);
        checks++;
        if (v !== 1'b0) begin
            errors++;
            $display("ERROR %0t %s: got %b expected 0", $time, name, v);
        end
    endtask

    task automatic check_quiet();
        check_low(aw_ready_o, "aw_ready_o");
        check_low(w_ready_o, "w_ready_o");
        check_low(ar_ready_o, "ar_ready_o");
        check_low(b_valid_o, "b_valid_o");
        check_low(r_valid_o, "r_valid_o");
        check_low(dec_valid_o, "dec_valid_o");
        check_low(i_dut.push, "i_dut.push");    // fetch to queue strobe
        check_low(i_dut.pop, "i_dut.pop");
    endtask

    task automatic check_rdata(input mem_sub_pkg::axil_r_t got, input mem_sub_pkg::axil_r_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t r_o: got data %h resp %b expected data %h resp %b",
                     $time, got.data, got.resp, exp.data, exp.resp);
        end
    endtask

    task automatic check_bresp(input mem_sub_pkg::axil_b_t got, input mem_sub_pkg::axil_b_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t b_o: got resp %b expected resp %b", $time, got.resp, exp.resp);
        end
    endtask

    task automatic check_decoded(input mem_sub_pkg::decoded_t got,
                                 input mem_sub_pkg::decoded_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h (%s) expected %h (%s)", $time, name,
                     got, got.opc.name(), exp, exp.opc.name());
        end
    endtask

    task automatic model_write(input logic [AW-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        for (int b = 0; b < 4; b++)
            if (strb[b])
                model_mem[{addr[AW-1:2], 2'(b)}] = data[8*b +: 8];
    endtask

    function automatic logic [31:0] model_word(input logic [AW-1:0] addr);
        return {model_mem[{addr[AW-1:2], 2'd3}], model_mem[{addr[AW-1:2], 2'd2}],
                model_mem[{addr[AW-1:2], 2'd1}], model_mem[{addr[AW-1:2], 2'd0}]};
    endfunction

    // rv32 base opcode map, low two bits 11 and bits 6:2 pick the class
    function automatic mem_sub_pkg::decoded_t expect_decode(input logic [AW-1:0] pc);
        logic [31:0]           w;
        mem_sub_pkg::decoded_t d;
        w        = model_word(pc);
        d.pc     = pc;
        d.instr  = w;
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.opc    = mem_sub_pkg::OPC_ILLEGAL;
        if (w[1:0] == 2'b11) begin
            case (w[6:2])
                5'b01101: d.opc = mem_sub_pkg::OPC_LUI;
                5'b00101: d.opc = mem_sub_pkg::OPC_AUIPC;
                5'b11011: d.opc = mem_sub_pkg::OPC_JAL;
                5'b11001: d.opc = mem_sub_pkg::OPC_JALR;
                5'b11000: d.opc = mem_sub_pkg::OPC_BRANCH;
                5'b00000: d.opc = mem_sub_pkg::OPC_LOAD;
                5'b01000: d.opc = mem_sub_pkg::OPC_STORE;
                5'b00100: d.opc = mem_sub_pkg::OPC_OP_IMM;
                5'b01100: d.opc = mem_sub_pkg::OPC_OP;
                5'b11100: d.opc = mem_sub_pkg::OPC_SYSTEM;
                default:  d.opc = mem_sub_pkg::OPC_ILLEGAL;
            endcase
        end
        return d;
    endfunction

    // ten of sixteen picks use a real opcode, the rest keep random bits
    function automatic logic [31:0] rand_instr();
        logic [31:0] w;
        logic [31:0] k;
        w = $random(seed);
        k = $random(seed);
        case (k[3:0])
            4'd0:    w[6:0] = 7'b0110111;
            4'd1:    w[6:0] = 7'b0010111;
            4'd2:    w[6:0] = 7'b1101111;
            4'd3:    w[6:0] = 7'b1100111;
            4'd4:    w[6:0] = 7'b1100011;
            4'd5:    w[6:0] = 7'b0000011;
            4'd6:    w[6:0] = 7'b0100011;
            4'd7:    w[6:0] = 7'b0010011;
            4'd8:    w[6:0] = 7'b0110011;
            4'd9:    w[6:0] = 7'b1110011;
            default: w[6:0] = w[6:0];
        endcase
        return w;
    endfunction

    task automatic axi_write(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        mem_sub_pkg::axil_b_t exp_b;
        logic [31:0]          dly;
        exp_b.resp = 2'b00;                     // okay
        aw_valid_i = 1'b1;
        aw_i.addr  = addr;
        w_valid_i  = 1'b1;
        w_i.data   = data;
        w_i.strb   = strb;
        @(negedge clk);
        while (!(aw_ready_o && w_ready_o))
            @(negedge clk);
        next_cycle();                           // accepted on that edge
        model_write(addr, data, strb);
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        dly        = $random(seed);
        repeat (dly[1:0])
            next_cycle();                       // host is slow to take the response
        b_ready_i  = 1'b1;
        @(negedge clk);
        while (!b_valid_o)
            @(negedge clk);
        check_bresp(b_o, exp_b);
        next_cycle();
        b_ready_i = 1'b0;
    endtask

    task automatic axi_read_check(input logic [AW-1:0] addr);
        mem_sub_pkg::axil_r_t exp_r;
        logic [31:0]          dly;
        ar_valid_i = 1'b1;
        ar_i.addr  = addr;
        @(negedge clk);
        while (!ar_ready_o)
            @(negedge clk);
        next_cycle();
        ar_valid_i = 1'b0;
        dly        = $random(seed);
        repeat (dly[1:0])
            next_cycle();                       // rdata has to survive the stall
        r_ready_i  = 1'b1;
        @(negedge clk);
        while (!r_valid_o)
            @(negedge clk);
        exp_r.data = model_word(addr);
        exp_r.resp = 2'b00;
        check_rdata(r_o, exp_r);
        next_cycle();
        r_ready_i = 1'b0;
    endtask

    task automatic redirect_to(input logic [AW-1:0] pc);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        next_cycle();
        redirect_valid_i = 1'b0;
    endtask

    task automatic wait_decodes(input int n);
        int target;
        target = dec_count + n;
        while (dec_count < target)
            next_cycle();
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    // consumer side, random or steady ready
    initial begin
        logic [31:0] rr;
        dec_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rr          = $random(ready_seed);
            dec_ready_i = rand_ready ? rr[0] : rst_n_i;
        end
    end

    // decoded stream monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rst_n_i && mon_en) begin
            if (stalled && !dec_valid_o) begin
                errors++;
                $display("dec_valid_o dropped at %0t while the output was stalled", $time);
            end
            if (stalled && dec_valid_o)
                check_decoded(dec_o, held, "dec_o while stalled");
            if (dec_valid_o && dec_ready_i) begin
                check_decoded(dec_o, expect_decode(exp_pc), "dec_o");
                exp_pc = exp_pc + AW'(4);
                dec_count++;
            end
            stalled = dec_valid_o && !dec_ready_i && !redirect_valid_i;
            held    = dec_o;
            if (redirect_valid_i)
                exp_pc = {redirect_pc_i[AW-1:2], 2'b00};    // sequence restarts here
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst_n_i          = 1'b0;
        aw_valid_i       = 1'b0;
        aw_i             = '0;
        w_valid_i        = 1'b0;
        w_i              = '0;
        b_ready_i        = 1'b0;
        ar_valid_i       = 1'b0;
        ar_i             = '0;
        r_ready_i        = 1'b0;
        fetch_en_i       = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        repeat (10) begin
            @(negedge clk);
            check_quiet();                      // quiet while in reset
        end
        next_cycle();
        rst_n_i = 1'b1;
        mon_en  = 1'b1;
        @(negedge clk);
        check_quiet();
        report_test("reset");
        next_cycle();

        for (int i = 0; i < N_AXI_RD; i++) begin
            r       = $random(seed);
            pool[i] = {1'b1, r[14:2], 2'b00};       // upper half, clear of programs
        end
        for (int i = 0; i < N_AXI_WR; i++) begin
            r   = $random(seed);
            s   = $random(seed);
            idx = (i < N_AXI_RD) ? i : int'(s[3:0]);    // every pool word gets a full write
            axi_write(pool[idx], r, (i < N_AXI_RD) ? 4'hf : s[7:4]);
        end
        for (int i = 0; i < N_AXI_RD; i++)
            axi_read_check(pool[i]);
        report_test("axi data path");

        for (int i = 0; i < N_PROG; i++)
            axi_write(RESET_PC + AW'(4 * i), rand_instr(), 4'hf);
        fetch_en_i = 1'b1;
        wait_decodes(N_SEQ);
        fetch_en_i = 1'b0;
        report_test("sequential decode");

        rand_ready = 1'b1;
        redirect_to(RESET_PC + AW'('h40));
        fetch_en_i = 1'b1;
        wait_decodes(N_BP);
        report_test("back-pressure");

        for (int i = 0; i < N_RED; i++) begin
            r = $random(seed);
            repeat (int'(r[3:0]) + 2)
                next_cycle();
            redirect_to(RESET_PC + {8'h00, r[13:8], 2'b00});
        end
        wait_decodes(N_RED_TAIL);
        report_test("redirect");

        rand_ready = 1'b0;
        fetch_en_i = 1'b0;
        next_cycle();
        redirect_to(RESET_PC + AW'('h100));     // parks the pc, nothing issues yet
        for (int i = 0; i < N_LATE; i++)
            axi_write(RESET_PC + AW'('h100 + 4 * i), rand_instr(), 4'hf);
        fetch_en_i = 1'b1;
        wait_decodes(N_LATE_DEC);
        fetch_en_i = 1'b0;
        report_test("data and instruction sides");

        repeat (4)
            next_cycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- logic/mem_sub_top.sv
// memory subsystem top
// dual port ram with an axi4-lite host on the data side and a
// fetch, queue and decode pipeline on the instruction side

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module mem_sub_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  mem_sub_pkg::axil_aw_t      aw_i,
    input  logic                       w_valid_i,
    output logic                       w_ready_o,
    input  mem_sub_pkg::axil_w_t       w_i,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    output mem_sub_pkg::axil_b_t       b_o,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  mem_sub_pkg::axil_ar_t      ar_i,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output mem_sub_pkg::axil_r_t       r_o,
    input  logic                       fetch_en_i,
    input  logic                       redirect_valid_i,
    input  logic [`MEM_SUB_ADDR_W-1:0] redirect_pc_i,
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output mem_sub_pkg::decoded_t      dec_o
);

    localparam int AW    = `MEM_SUB_ADDR_W;
    localparam int CNT_W = $clog2(`MEM_SUB_QUEUE_DEPTH + 1);

    logic                      data_en;         // axi port to ram
    logic [3:0]                data_we;
    logic [AW-1:0]             data_addr;
    logic [31:0]               data_wdata;
    logic [31:0]               data_rdata;
    logic [AW-1:0]             instr_addr;      // fetch to ram
    logic [31:0]               instr;
    logic [CNT_W-1:0]          free_cnt;        // queue credit
    logic                      push;
    mem_sub_pkg::fetch_entry_t push_entry;
    logic                      pop;
    logic                      head_valid;
    mem_sub_pkg::fetch_entry_t head;

    dual_port_ram i_ram (
        .clk          (clk),
        .instr_addr_i (instr_addr),
        .instr_o      (instr),
        .data_en_i    (data_en),
        .data_we_i    (data_we),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .data_rdata_o (data_rdata)
    );

    axil_data_port i_axil (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_o   (aw_ready_o),
        .aw_i         (aw_i),
        .w_valid_i    (w_valid_i),
        .w_ready_o    (w_ready_o),
        .w_i          (w_i),
        .b_valid_o    (b_valid_o),
        .b_ready_i    (b_ready_i),
        .b_o          (b_o),
        .ar_valid_i   (ar_valid_i),
        .ar_ready_o   (ar_ready_o),
        .ar_i         (ar_i),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i),
        .r_o          (r_o),
        .data_en_o    (data_en),
        .data_we_o    (data_we),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata)
    );

    instr_fetch #(.CNT_W(CNT_W)) i_fetch (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .fetch_en_i       (fetch_en_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_addr_o     (instr_addr),
        .instr_i          (instr),
        .free_cnt_i       (free_cnt),
        .push_o           (push),
        .push_entry_o     (push_entry)
    );

    // a redirect empties everything behind the fetch unit
    fetch_queue #(.DEPTH(`MEM_SUB_QUEUE_DEPTH)) i_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (redirect_valid_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .free_cnt_o   (free_cnt),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head)
    );

    instr_decode i_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (redirect_valid_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .dec_valid_o  (dec_valid_o),
        .dec_ready_i  (dec_ready_i),
        .dec_o        (dec_o)
    );

endmodule

//--- logic/instr_decode.sv
// instruction decoder
// classifies the rv32 major opcode, extracts register and funct3 fields and
// holds the result in a valid/ready output register

`timescale 1ns/1ps

module instr_decode (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      head_valid_i,
    input  mem_sub_pkg::fetch_entry_t head_i,
    output logic                      pop_o,
    output logic                      dec_valid_o,
    input  logic                      dec_ready_i,
    output mem_sub_pkg::decoded_t     dec_o
);

    mem_sub_pkg::opc_e     opc;
    mem_sub_pkg::decoded_t dec_next;

    always_comb begin
        case (head_i.instr[6:0])
            7'b0110111: opc = mem_sub_pkg::OPC_LUI;
            7'b0010111: opc = mem_sub_pkg::OPC_AUIPC;
            7'b1101111: opc = mem_sub_pkg::OPC_JAL;
            7'b1100111: opc = mem_sub_pkg::OPC_JALR;
            7'b1100011: opc = mem_sub_pkg::OPC_BRANCH;
            7'b0000011: opc = mem_sub_pkg::OPC_LOAD;
            7'b0100011: opc = mem_sub_pkg::OPC_STORE;
            7'b0010011: opc = mem_sub_pkg::OPC_OP_IMM;
            7'b0110011: opc = mem_sub_pkg::OPC_OP;
            7'b1110011: opc = mem_sub_pkg::OPC_SYSTEM;
            default:    opc = mem_sub_pkg::OPC_ILLEGAL;
        endcase
    end

    // fields are extracted at their fixed rv32 positions for every class
    assign dec_next.pc     = head_i.pc;
    assign dec_next.opc    = opc;
    assign dec_next.rd     = head_i.instr[11:7];
    assign dec_next.funct3 = head_i.instr[14:12];
    assign dec_next.rs1    = head_i.instr[19:15];
    assign dec_next.rs2    = head_i.instr[24:20];
    assign dec_next.instr  = head_i.instr;

    // take a new word when the output is empty or leaving
    assign pop_o = head_valid_i && !flush_i && (!dec_valid_o || dec_ready_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i)
            dec_valid_o <= 1'b0;
        else if (pop_o)
            dec_valid_o <= 1'b1;
        else if (dec_ready_i)
            dec_valid_o <= 1'b0;        // taken, nothing behind it
    end

    always_ff @(posedge clk) begin
        if (pop_o)
            dec_o <= dec_next;          // held while stalled
    end

endmodule

//--- logic/fetch_queue.sv
// fetch queue
// circular buffer of fetched words with their pcs, flushed on redirect

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module fetch_queue #(
    parameter int DEPTH = `MEM_SUB_QUEUE_DEPTH,
    parameter int CNT_W = $clog2(DEPTH + 1),
    parameter int PTR_W = $clog2(DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      push_i,
    input  mem_sub_pkg::fetch_entry_t push_entry_i,
    output logic [CNT_W-1:0]          free_cnt_o,
    input  logic                      pop_i,
    output logic                      head_valid_o,
    output mem_sub_pkg::fetch_entry_t head_o
);

    mem_sub_pkg::fetch_entry_t mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;    // wraps for any depth
    endfunction

    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign free_cnt_o   = CNT_W'(DEPTH) - count_q;

    always_ff @(posedge clk) begin
        if (push_i)
            mem[wr_ptr_q] <= push_entry_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // none or both
            endcase
        end
    end

    // the fetch credit and the decoder pop rule keep these from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> count_q != CNT_W'(DEPTH));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> count_q != '0);

endmodule

//--- logic/instr_fetch.sv
// instruction fetch unit
// walks the pc, issues instruction reads while the queue has credit and
// turns each returning word into a queue entry, redirect drops the read in flight

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module instr_fetch #(
    parameter int CNT_W = $clog2(`MEM_SUB_QUEUE_DEPTH + 1)
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       fetch_en_i,
    input  logic                       redirect_valid_i,
    input  logic [`MEM_SUB_ADDR_W-1:0] redirect_pc_i,
    output logic [`MEM_SUB_ADDR_W-1:0] instr_addr_o,
    input  logic [31:0]                instr_i,
    input  logic [CNT_W-1:0]           free_cnt_i,
    output logic                       push_o,
    output mem_sub_pkg::fetch_entry_t  push_entry_o
);

    localparam int            AW       = `MEM_SUB_ADDR_W;
    localparam logic [AW-1:0] RESET_PC = `MEM_SUB_RESET_PC;

    logic [AW-1:0] pc_q;
    logic          inflight_q;              // a word returns this cycle
    logic [AW-1:0] inflight_pc_q;
    logic          issue;

    // free slots must cover the word already in flight plus this one
    assign issue = fetch_en_i && !redirect_valid_i &&
                   (free_cnt_i > {{(CNT_W-1){1'b0}}, inflight_q});

    assign instr_addr_o = pc_q;

    assign push_o             = inflight_q && !redirect_valid_i;
    assign push_entry_o.pc    = inflight_pc_q;
    assign push_entry_o.instr = instr_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            inflight_q <= 1'b0;
        end else if (redirect_valid_i) begin
            pc_q       <= {redirect_pc_i[AW-1:2], 2'b00};  // restart here
            inflight_q <= 1'b0;                          // older word is dropped
        end else begin
            inflight_q <= issue;
            if (issue)
                pc_q <= pc_q + AW'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            inflight_pc_q <= pc_q;          // pc of the word on its way
    end

endmodule

//--- logic/axil_data_port.sv
// axi4-lite slave for the ram data port
// one transaction at a time, writes win over reads, responses are held
// until the host takes them

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module axil_data_port (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  mem_sub_pkg::axil_aw_t      aw_i,
    input  logic                       w_valid_i,
    output logic                       w_ready_o,
    input  mem_sub_pkg::axil_w_t       w_i,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    output mem_sub_pkg::axil_b_t       b_o,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  mem_sub_pkg::axil_ar_t      ar_i,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output mem_sub_pkg::axil_r_t       r_o,
    output logic                       data_en_o,
    output logic [3:0]                 data_we_o,
    output logic [`MEM_SUB_ADDR_W-1:0] data_addr_o,
    output logic [31:0]                data_wdata_o,
    input  logic [31:0]                data_rdata_i
);

    localparam int AW = `MEM_SUB_ADDR_W;

    mem_sub_pkg::axil_state_e state_q;
    logic                     idle;
    logic                     wr_acc;           // write accepted this cycle
    logic                     rd_acc;           // read accepted this cycle
    logic [AW-1:0]            rd_addr_q;        // word address of the pending read

    assign idle   = (state_q == mem_sub_pkg::IDLE);
    assign wr_acc = idle && aw_valid_i && w_valid_i;
    assign rd_acc = idle && ar_valid_i && !wr_acc;

    assign aw_ready_o = wr_acc;                 // aw and w taken together
    assign w_ready_o  = wr_acc;
    assign ar_ready_o = rd_acc;

    // the read stays enabled while the response waits, so the ram keeps
    // returning the same word and rdata holds until rready
    assign data_en_o    = wr_acc || rd_acc || (state_q == mem_sub_pkg::READ_RESP);
    assign data_we_o    = wr_acc ? w_i.strb : 4'b0000;
    assign data_wdata_o = w_i.data;

    always_comb begin
        if (wr_acc)
            data_addr_o = {aw_i.addr[AW-1:2], 2'b00};
        else if (rd_acc)
            data_addr_o = {ar_i.addr[AW-1:2], 2'b00};
        else
            data_addr_o = rd_addr_q;
    end

    assign b_valid_o = (state_q == mem_sub_pkg::WRITE_RESP);
    assign r_valid_o = (state_q == mem_sub_pkg::READ_RESP);
    assign b_o.resp  = 2'b00;                   // okay
    assign r_o.resp  = 2'b00;
    assign r_o.data  = data_rdata_i;

    always_ff @(posedge clk) begin
        if (rd_acc)
            rd_addr_q <= {ar_i.addr[AW-1:2], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= mem_sub_pkg::IDLE;
        end else begin
            case (state_q)
                mem_sub_pkg::IDLE: begin
                    if (wr_acc)
                        state_q <= mem_sub_pkg::WRITE_RESP;
                    else if (rd_acc)
                        state_q <= mem_sub_pkg::READ_RESP;
                end
                mem_sub_pkg::WRITE_RESP: if (b_ready_i) state_q <= mem_sub_pkg::IDLE;
                mem_sub_pkg::READ_RESP:  if (r_ready_i) state_q <= mem_sub_pkg::IDLE;
                default:                 state_q <= mem_sub_pkg::IDLE;
            endcase
        end
    end

    // a stalled response keeps its valid and payload
    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

endmodule

//--- ram/dual_port_ram.sv
// dual port ram
// byte array with a registered 32-bit instruction read port and a
// data port with byte write enables, both one cycle address to data

`timescale 1ns/1ps
`include "mem_sub_defs.svh"

module dual_port_ram (
    input  logic                       clk,
    input  logic [`MEM_SUB_ADDR_W-1:0] instr_addr_i,
    output logic [31:0]                instr_o,
    input  logic                       data_en_i,
    input  logic [3:0]                 data_we_i,
    input  logic [`MEM_SUB_ADDR_W-1:0] data_addr_i,
    input  logic [31:0]                data_wdata_i,
    output logic [31:0]                data_rdata_o
);

    localparam int AW = `MEM_SUB_ADDR_W;

    logic [7:0]    mem [0:(2**AW)-1];       // little-endian bytes
    logic [AW-3:0] data_word;               // word index of the data port
    logic [AW-3:0] instr_word;

    assign data_word  = data_addr_i[AW-1:2];
    assign instr_word = instr_addr_i[AW-1:2];

    // data port, write when any enable is set, otherwise read
    always_ff @(posedge clk) begin
        if (data_en_i) begin
            if (data_we_i != 4'b0000) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_we_i[b])
                        mem[{data_word, 2'(b)}] <= data_wdata_i[8*b +: 8];
                end
            end else begin
                for (int b = 0; b < 4; b++)
                    data_rdata_o[8*b +: 8] <= mem[{data_word, 2'(b)}];
            end
        end else begin
            data_rdata_o <= '0;                 // idle port reads back zero
        end
    end

    // instruction port, read every cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++)
            instr_o[8*b +: 8] <= mem[{instr_word, 2'(b)}];
    end

    // masters only issue word-aligned data accesses
    a_data_aligned: assert property (@(posedge clk)
        data_en_i |-> data_addr_i[1:0] == 2'b00);

endmodule

//--- common/mem_sub_pkg.sv
// memory subsystem types
// axi4-lite channel payloads, fetch queue entry, decoded instruction
// and the state and opcode enums

`include "mem_sub_defs.svh"

package mem_sub_pkg;

    typedef struct packed {
        logic [`MEM_SUB_ADDR_W-1:0] addr;   // byte address, bits 1:0 ignored
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;                  // one bit per byte lane
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;                   // always okay
    } axil_b_t;

    typedef struct packed {
        logic [`MEM_SUB_ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,                         // bvalid pending
        READ_RESP                           // rvalid pending
    } axil_state_e;

    typedef struct packed {
        logic [`MEM_SUB_ADDR_W-1:0] pc;
        logic [31:0]                instr;
    } fetch_entry_t;

    typedef enum logic [3:0] {
        OPC_LUI,
        OPC_AUIPC,
        OPC_JAL,
        OPC_JALR,
        OPC_BRANCH,
        OPC_LOAD,
        OPC_STORE,
        OPC_OP_IMM,
        OPC_OP,
        OPC_SYSTEM,
        OPC_ILLEGAL                         // any other major opcode
    } opc_e;

    typedef struct packed {
        logic [`MEM_SUB_ADDR_W-1:0] pc;
        opc_e                       opc;
        logic [4:0]                 rd;
        logic [4:0]                 rs1;
        logic [4:0]                 rs2;
        logic [2:0]                 funct3;
        logic [31:0]                instr;  // raw word
    } decoded_t;

endpackage

//--- common/mem_sub_defs.svh
// memory subsystem build parameters
// address width, fetch queue depth and reset program counter

`ifndef MEM_SUB_DEFS_SVH
`define MEM_SUB_DEFS_SVH

// byte address width, 64 KB of ram
`define MEM_SUB_ADDR_W 16

// fetch queue entries, 2, 4 or 8
`define MEM_SUB_QUEUE_DEPTH 4

// first fetch address after reset
`define MEM_SUB_RESET_PC 'h0

`endif
